// ==== bench/core_tb.sv ====
`include "core_defines.svh"

module core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NROWS = 6;
    localparam int MAX_PROG = 16;
    localparam int MAX_EV = 16;
    localparam int MAX_HND = 4;
    // 200 cycles for each row of the table
    localparam int LIMIT = 200 * NROWS;

    logic                        clk;
    logic                        rst;
    logic                        interrupt;
    logic [`INST_ADDR_WIDTH-1:0] fetch_pc;
    logic                        fetch_valid;
    logic [`INST_ADDR_WIDTH-1:0] inst_data;
    logic                        wb_valid;
    logic                        wb_ready;
    logic [4:0]                  wb_rd;
    logic [`INST_ADDR_WIDTH-1:0] wb_data;
    logic                        exc_valid;
    core_pkg::exc_cause_e        exc_cause;
    logic [`INST_ADDR_WIDTH-1:0] exc_pc;

    ////////////////////
    // test table
    ////////////////////

    string       tname [NROWS];
    bit          rnd [NROWS];
    int          irq_at [NROWS];
    logic [31:0] prog [NROWS][MAX_PROG];
    int          plen [NROWS];
    logic [31:0] hnd [NROWS][MAX_HND];
    int          hlen [NROWS];
    // expected exception and writeback events in order
    bit          ev_exc [NROWS][MAX_EV];
    logic [31:0] ev_a [NROWS][MAX_EV];
    logic [31:0] ev_b [NROWS][MAX_EV];
    int          ev_n [NROWS];

    int          nrow;
    int          brow;
    int          cur;
    int          got;
    int          cyc;
    int          cycles;
    int          mismatches;
    int          failures;
    integer      seed;
    logic [31:0] imem [MAX_PROG];
    logic [31:0] hmem [MAX_HND];
    logic [31:0] prog_off;
    logic [31:0] exc_off;

    core_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // memory model
    ////////////////////

    // anything outside the loaded areas reads as an unknown opcode
    function automatic logic [31:0] fill_word(logic [31:0] a);
        return {6'h3f, a[25:0] ^ {20'd0, a[31:26]}};
    endfunction

    assign prog_off = fetch_pc - `RESET_PC;
    assign exc_off  = fetch_pc - `EXC_ENTRY;

    // combinational read in the same cycle as fetch_pc
    always_comb begin
        if (prog_off < 32'(4 * MAX_PROG)) begin
            inst_data = imem[prog_off[5:2]];
        end else if (exc_off < 32'(4 * MAX_HND)) begin
            inst_data = hmem[exc_off[3:2]];
        end else begin
            inst_data = fill_word(fetch_pc);
        end
    end

    // instruction encoders with the opcode in 31:26
    function automatic logic [31:0] enc_i(core_pkg::opcode_e op, logic [4:0] rd,
                                          logic [4:0] rj, logic [15:0] imm);
        return {2'b00, op, rd, rj, imm};
    endfunction

    function automatic logic [31:0] enc_r(core_pkg::opcode_e op, logic [4:0] rd,
                                          logic [4:0] rj, logic [4:0] rk);
        return {2'b00, op, rd, rj, rk, 11'd0};
    endfunction

    function automatic logic [31:0] enc_u(logic [4:0] rd, logic [19:0] u);
        return {2'b00, core_pkg::OP_LU12I, rd, 1'b0, u};
    endfunction

    task automatic new_row(string name, bit rand_ready, int irq);
        brow = nrow;
        tname[brow] = name;
        rnd[brow] = rand_ready;
        irq_at[brow] = irq;
        nrow++;
    endtask

    task automatic put_inst(logic [31:0] w);
        prog[brow][plen[brow]] = w;
        plen[brow]++;
    endtask

    task automatic put_handler(logic [31:0] w);
        hnd[brow][hlen[brow]] = w;
        hlen[brow]++;
    endtask

    task automatic expect_wb(logic [4:0] rd, logic [31:0] d);
        ev_exc[brow][ev_n[brow]] = 1'b0;
        ev_a[brow][ev_n[brow]] = {27'd0, rd};
        ev_b[brow][ev_n[brow]] = d;
        ev_n[brow]++;
    endtask

    task automatic expect_exc(core_pkg::exc_cause_e c, logic [31:0] pc);
        ev_exc[brow][ev_n[brow]] = 1'b1;
        ev_a[brow][ev_n[brow]] = 32'(c);
        ev_b[brow][ev_n[brow]] = pc;
        ev_n[brow]++;
    endtask

    // taken forward beq, a bne loop run 3 times and a b over one word
    task automatic branch_program();
        put_inst(enc_i(core_pkg::OP_ADDI, 5'd1, 5'd0, 16'd3));
        put_inst(enc_i(core_pkg::OP_ADDI, 5'd2, 5'd0, 16'd0));
        put_inst(enc_i(core_pkg::OP_BEQ, 5'd0, 5'd0, 16'd8));
        put_inst(enc_i(core_pkg::OP_ADDI, 5'd9, 5'd0, 16'h99));
        put_inst(enc_i(core_pkg::OP_ADDI, 5'd2, 5'd2, 16'd1));
        put_inst(enc_i(core_pkg::OP_ADDI, 5'd1, 5'd1, 16'hffff));
        // back to 0x110
        put_inst(enc_i(core_pkg::OP_BNE, 5'd1, 5'd0, 16'hfff8));
        put_inst(enc_i(core_pkg::OP_B, 5'd0, 5'd0, 16'd8));
        put_inst(enc_i(core_pkg::OP_ADDI, 5'd9, 5'd0, 16'h98));
        put_inst(enc_i(core_pkg::OP_ADDI, 5'd3, 5'd0, 16'h77));
        expect_wb(5'd1, 32'd3);
        expect_wb(5'd2, 32'd0);
        for (int i = 1; i <= 3; i++) begin
            expect_wb(5'd2, 32'(i));
            expect_wb(5'd1, 32'(3 - i));
        end
        expect_wb(5'd3, 32'h77);
    endtask

    task automatic build_table();
        new_row("alu", 1'b0, 0);
        put_inst(enc_i(core_pkg::OP_ADDI, 5'd1, 5'd0, 16'd5));
        put_inst(enc_i(core_pkg::OP_ADDI, 5'd2, 5'd0, 16'hfffd));
        put_inst(enc_u(5'd3, 20'h12345));
        // r0 target writes nothing back
        put_inst(enc_i(core_pkg::OP_ADDI, 5'd0, 5'd0, 16'd9));
        put_inst(enc_r(core_pkg::OP_ADD, 5'd4, 5'd1, 5'd2));
        put_inst(enc_r(core_pkg::OP_SUB, 5'd5, 5'd1, 5'd2));
        put_inst(enc_r(core_pkg::OP_AND, 5'd6, 5'd3, 5'd2));
        put_inst(enc_r(core_pkg::OP_OR, 5'd7, 5'd1, 5'd3));
        expect_wb(5'd1, 32'd5);
        expect_wb(5'd2, 32'hffff_fffd);
        expect_wb(5'd3, 32'h1234_5000);
        expect_wb(5'd4, 32'd2);
        expect_wb(5'd5, 32'd8);
        expect_wb(5'd6, 32'h1234_5000);
        expect_wb(5'd7, 32'h1234_5005);

        new_row("depend", 1'b0, 0);
        put_inst(enc_i(core_pkg::OP_ADDI, 5'd1, 5'd0, 16'd1));
        put_inst(enc_i(core_pkg::OP_ADDI, 5'd1, 5'd1, 16'd1));
        put_inst(enc_r(core_pkg::OP_ADD, 5'd2, 5'd1, 5'd1));
        put_inst(enc_r(core_pkg::OP_SUB, 5'd3, 5'd2, 5'd1));
        put_inst(enc_r(core_pkg::OP_OR, 5'd4, 5'd3, 5'd2));
        put_inst(enc_r(core_pkg::OP_AND, 5'd1, 5'd4, 5'd2));
        expect_wb(5'd1, 32'd1);
        expect_wb(5'd1, 32'd2);
        expect_wb(5'd2, 32'd4);
        expect_wb(5'd3, 32'd2);
        expect_wb(5'd4, 32'd6);
        expect_wb(5'd1, 32'd4);

        new_row("branch", 1'b0, 0);
        branch_program();

        // b to 0x10a and on into the handler
        new_row("misalign", 1'b0, 0);
        put_inst(enc_i(core_pkg::OP_ADDI, 5'd1, 5'd0, 16'd7));
        put_inst(enc_i(core_pkg::OP_B, 5'd0, 5'd0, 16'd6));
        put_inst(enc_i(core_pkg::OP_ADDI, 5'd2, 5'd0, 16'd1));
        put_handler(enc_i(core_pkg::OP_ADDI, 5'd5, 5'd0, 16'h33));
        expect_wb(5'd1, 32'd7);
        expect_exc(core_pkg::EXC_ADEF, 32'h0000_010a);
        expect_wb(5'd5, 32'h33);

        // pulse sampled at the 4th rising edge out of reset tags the next fetch at 0x10c
        new_row("interrupt", 1'b0, 3);
        for (int i = 1; i <= 6; i++) begin
            put_inst(enc_i(core_pkg::OP_ADDI, 5'(i), 5'd0, 16'(i * 17)));
        end
        put_handler(enc_i(core_pkg::OP_ADDI, 5'd10, 5'd0, 16'h55));
        expect_wb(5'd1, 32'd17);
        expect_wb(5'd2, 32'd34);
        expect_wb(5'd3, 32'd51);
        expect_exc(core_pkg::EXC_INT, 32'h0000_010c);
        expect_wb(5'd10, 32'h55);

        new_row("backpressure", 1'b1, 0);
        branch_program();
    endtask

    task automatic load_memory(int r);
        for (int i = 0; i < MAX_PROG; i++) begin
            imem[i] = (i < plen[r]) ? prog[r][i] : fill_word(`RESET_PC + 32'(4 * i));
        end
        for (int i = 0; i < MAX_HND; i++) begin
            hmem[i] = (i < hlen[r]) ? hnd[r][i] : fill_word(`EXC_ENTRY + 32'(4 * i));
        end
    endtask

    ////////////////////
    // checking
    ////////////////////

    task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            mismatches++;
            $display("Fail %s %s[%0d]: expected %h actual %h", tname[cur], what, got, exp, act);
        end
    endtask

    task automatic record_event(bit is_exc, logic [31:0] a, logic [31:0] b);
        if (got >= ev_n[cur]) begin
            mismatches++;
            $display("test %s: an extra event appeared after the expected ones", tname[cur]);
        end else begin
            check_value("kind", {31'd0, ev_exc[cur][got]}, {31'd0, is_exc});
            check_value(is_exc ? "cause" : "rd", ev_a[cur][got], a);
            check_value(is_exc ? "pc" : "data", ev_b[cur][got], b);
        end
        got++;
    endtask

    // registered outputs still hold their values from before this edge
    always @(posedge clk) begin
        if (rst) begin
            got = 0;
        end else begin
            if (wb_valid && wb_ready) begin
                record_event(1'b0, {27'd0, wb_rd}, wb_data);
            end
            if (exc_valid) begin
                record_event(1'b1, 32'(exc_cause), exc_pc);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: the run went past %0d cycles", LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    // one falling edge with a fresh wb_ready
    task automatic step();
        logic [31:0] rv;
        @(negedge clk);
        if (rnd[cur]) begin
            rv = $random(seed);
            wb_ready = rv[0];
        end else begin
            wb_ready = 1'b1;
        end
    endtask

    initial begin
        rst = 1'b1;
        interrupt = 1'b0;
        wb_ready = 1'b1;
        seed = 58;
        cur = 0;
        build_table();
        for (int r = 0; r < NROWS; r++) begin
            rst = 1'b1;
            interrupt = 1'b0;
            cur = r;
            load_memory(r);
            step();
            step();
            // outputs held low by reset
            check_value("fetch_valid in reset", 32'd0, {31'd0, fetch_valid});
            check_value("wb_valid in reset", 32'd0, {31'd0, wb_valid});
            check_value("exc_valid in reset", 32'd0, {31'd0, exc_valid});
            rst = 1'b0;
            cyc = 0;
            while (got < ev_n[r] && cyc < 150) begin
                step();
                cyc++;
                interrupt = (cyc == irq_at[r]);
                // first fetch right after reset release
                if (cyc == 1) begin
                    check_value("fetch_valid", 32'd1, {31'd0, fetch_valid});
                    check_value("fetch_pc", `RESET_PC, fetch_pc);
                end
            end
            interrupt = 1'b0;
            if (got < ev_n[r]) begin
                failures++;
                $display("test %s: only %0d of %0d expected events seen", tname[r], got, ev_n[r]);
            end
            // idle tail to catch stray writebacks
            repeat (10) step();
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== common/core_defines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// address and data width
`define INST_ADDR_WIDTH 32

// first fetch address after reset
`define RESET_PC 32'h0000_0100

// fetch target on any exception
`define EXC_ENTRY 32'h0000_0200

// register file depth
`define NUM_REGS 32

`endif

// ==== common/core_pkg.sv ====
package core_pkg;

    ////////////////////
    // instruction fields
    ////////////////////

    // opcode field, bits 31:26
    localparam int OPC_W = 6;
    // rd / rj / rk index width
    localparam int REG_ADDR_W = 5;
    // signed immediate, bits 15:0
    localparam int IMM_W = 16;
    // lu12i upper value, bits 19:0
    localparam int UIMM_W = 20;

    ////////////////////
    // decoded operation
    ////////////////////

    // the opcode field carries these codes directly
    // anything above OP_B decodes as a nop
    typedef enum logic [3:0] {
        OP_ADDI  = 4'd0,
        OP_ADD   = 4'd1,
        OP_SUB   = 4'd2,
        OP_AND   = 4'd3,
        OP_OR    = 4'd4,
        OP_LU12I = 4'd5,
        OP_BEQ   = 4'd6,
        OP_BNE   = 4'd7,
        OP_B     = 4'd8,
        OP_NOP   = 4'd15
    } opcode_e;

    // exception cause carried down the pipe
    typedef enum logic [1:0] {
        EXC_NONE = 2'd0,
        EXC_INT  = 2'd1,
        EXC_ADEF = 2'd2
    } exc_cause_e;

endpackage

// ==== fetch/pc_reg.sv ====
`include "core_defines.svh"

module pc_reg (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        stall,
    input  logic                        pred_taken,
    input  logic [`INST_ADDR_WIDTH-1:0] pred_target,
    input  logic                        branch_flush,
    input  logic [`INST_ADDR_WIDTH-1:0] branch_actual_addr,
    input  logic                        exception_flush,
    input  logic                        interrupt,
    output logic [`INST_ADDR_WIDTH-1:0] fetch_pc,
    output logic                        fetch_valid,
    output core_pkg::exc_cause_e        fetch_exc
);

    // interrupt seen, not yet attached to a fetch
    logic int_pending;
    // current fetch handed to decode and kept
    logic fetch_taken;

    // a flush in the same cycle throws the fetch away
    assign fetch_taken = fetch_valid && !stall && !branch_flush && !exception_flush;

    // tag of the current fetch
    // interrupt wins over the alignment check
    assign fetch_exc = int_pending              ? core_pkg::EXC_INT  :
                       (fetch_pc[1:0] != 2'b00) ? core_pkg::EXC_ADEF :
                                                  core_pkg::EXC_NONE;

    ////////////////////
    // interrupt latch
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            int_pending <= 1'b0;
        end else begin
            // held until a tagged fetch really enters decode
            int_pending <= interrupt || (int_pending && !fetch_taken);
        end
    end

    ////////////////////
    // fetch address
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= 1'b1;
        end
    end

    // priority: exception, stall, mispredict, prediction, sequential
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pc <= `RESET_PC;
        end else if (exception_flush) begin
            fetch_pc <= `EXC_ENTRY;
        end else if (stall || !fetch_valid) begin
            // no handshake, keep the address
            fetch_pc <= fetch_pc;
        end else if (branch_flush) begin
            fetch_pc <= branch_actual_addr;
        end else if (pred_taken) begin
            fetch_pc <= pred_target;
        end else begin
            fetch_pc <= fetch_pc + 32'd4;
        end
    end

endmodule

// ==== files.f ====
+incdir+common
common/core_pkg.sv
fetch/pc_reg.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/core_top.sv
bench/core_tb.sv

// ==== logic/core_top.sv ====
`include "core_defines.svh"

module core_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            interrupt,
    // instruction memory, combinational read
    output logic [`INST_ADDR_WIDTH-1:0]     fetch_pc,
    output logic                            fetch_valid,
    input  logic [`INST_ADDR_WIDTH-1:0]     inst_data,
    // writeback
    output logic                            wb_valid,
    input  logic                            wb_ready,
    output logic [core_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [`INST_ADDR_WIDTH-1:0]     wb_data,
    // exception report
    output logic                            exc_valid,
    output core_pkg::exc_cause_e            exc_cause,
    output logic [`INST_ADDR_WIDTH-1:0]     exc_pc
);

    // fetch / decode
    core_pkg::exc_cause_e            fetch_exc;
    logic                            dec_ready;
    logic                            stall;
    logic                            pred_taken;
    logic [`INST_ADDR_WIDTH-1:0]     pred_target;
    // decode / execute
    logic                            ex_valid;
    logic                            ex_ready;
    core_pkg::opcode_e               ex_op;
    logic [`INST_ADDR_WIDTH-1:0]     ex_pc;
    logic [core_pkg::REG_ADDR_W-1:0] ex_rd;
    logic [`INST_ADDR_WIDTH-1:0]     ex_a;
    logic [`INST_ADDR_WIDTH-1:0]     ex_b;
    logic [`INST_ADDR_WIDTH-1:0]     ex_imm;
    logic                            ex_wen;
    logic                            ex_pred_taken;
    core_pkg::exc_cause_e            ex_exc;
    // execute / result
    logic                            res_valid;
    logic                            res_ready;
    logic [core_pkg::REG_ADDR_W-1:0] res_rd;
    logic [`INST_ADDR_WIDTH-1:0]     res_data;
    logic                            res_wen;
    logic [`INST_ADDR_WIDTH-1:0]     res_pc;
    core_pkg::exc_cause_e            res_exc;
    // redirects
    logic                            branch_flush;
    logic [`INST_ADDR_WIDTH-1:0]     branch_actual_addr;
    logic                            exception_flush;
    logic                            flush;
    logic                            wb_fire;

    assign stall   = !dec_ready;
    // either redirect clears decode
    assign flush   = branch_flush || exception_flush;
    assign wb_fire = wb_valid && wb_ready;

    // port names match the wires above
    pc_reg        u_pc_reg  (.*);
    decode_stage  u_decode  (.*);
    execute_stage u_execute (.*);
    result_stage  u_result  (.*);

endmodule

// ==== logic/decode_stage.sv ====
`include "core_defines.svh"

module decode_stage (
    input  logic                            clk,
    input  logic                            rst,
    // from fetch
    input  logic [`INST_ADDR_WIDTH-1:0]     fetch_pc,
    input  logic                            fetch_valid,
    input  logic [`INST_ADDR_WIDTH-1:0]     inst_data,
    input  core_pkg::exc_cause_e            fetch_exc,
    output logic                            dec_ready,
    // to execute
    output logic                            ex_valid,
    input  logic                            ex_ready,
    output core_pkg::opcode_e               ex_op,
    output logic [`INST_ADDR_WIDTH-1:0]     ex_pc,
    output logic [core_pkg::REG_ADDR_W-1:0] ex_rd,
    output logic [`INST_ADDR_WIDTH-1:0]     ex_a,
    output logic [`INST_ADDR_WIDTH-1:0]     ex_b,
    output logic [`INST_ADDR_WIDTH-1:0]     ex_imm,
    output logic                            ex_wen,
    output logic                            ex_pred_taken,
    output core_pkg::exc_cause_e            ex_exc,
    // static prediction to fetch
    output logic                            pred_taken,
    output logic [`INST_ADDR_WIDTH-1:0]     pred_target,
    input  logic                            flush,
    // writeback handshake
    input  logic                            wb_fire,
    input  logic [core_pkg::REG_ADDR_W-1:0] wb_rd,
    input  logic [`INST_ADDR_WIDTH-1:0]     wb_data
);

    logic [core_pkg::OPC_W-1:0]      opc;
    logic [core_pkg::REG_ADDR_W-1:0] rd;
    logic [core_pkg::REG_ADDR_W-1:0] rj;
    logic [core_pkg::REG_ADDR_W-1:0] rk;
    logic [core_pkg::REG_ADDR_W-1:0] src1;
    logic [core_pkg::REG_ADDR_W-1:0] src2;
    logic [core_pkg::IMM_W-1:0]      imm16;
    logic [core_pkg::UIMM_W-1:0]     uimm;
    logic [`INST_ADDR_WIDTH-1:0]     imm;
    logic [`INST_ADDR_WIDTH-1:0]     rdata1;
    logic [`INST_ADDR_WIDTH-1:0]     rdata2;
    core_pkg::opcode_e               op;
    logic                            is_alu_rr;
    logic                            is_cond_br;
    logic                            use1;
    logic                            use2;
    logic                            wen;
    logic                            hazard;
    logic                            can_issue;
    logic                            accept;
    logic [`INST_ADDR_WIDTH-1:0]     regs [`NUM_REGS];
    // one pending bit per register
    logic [`NUM_REGS-1:0]            pending;
    logic [`NUM_REGS-1:0]            pending_next;

    ////////////////////
    // field decode
    ////////////////////

    assign opc   = inst_data[31:26];
    assign rd    = inst_data[25:21];
    assign rj    = inst_data[20:16];
    assign rk    = inst_data[15:11];
    assign imm16 = inst_data[core_pkg::IMM_W-1:0];
    assign uimm  = inst_data[core_pkg::UIMM_W-1:0];

    // unknown codes and tagged fetches run as nops
    always_comb begin
        if (fetch_exc != core_pkg::EXC_NONE || int'(opc) > int'(core_pkg::OP_B)) begin
            op = core_pkg::OP_NOP;
        end else begin
            op = core_pkg::opcode_e'(opc[3:0]);
        end
    end

    assign is_cond_br = (op == core_pkg::OP_BEQ) || (op == core_pkg::OP_BNE);
    assign is_alu_rr  = (op == core_pkg::OP_ADD) || (op == core_pkg::OP_SUB) ||
                        (op == core_pkg::OP_AND) || (op == core_pkg::OP_OR);

    // branches compare rd against rj
    assign src1 = is_cond_br ? rd : rj;
    assign src2 = is_cond_br ? rj : rk;
    assign use1 = is_alu_rr || is_cond_br || (op == core_pkg::OP_ADDI);
    assign use2 = is_alu_rr || is_cond_br;
    // r0 never becomes pending
    assign wen  = (is_alu_rr || op == core_pkg::OP_ADDI || op == core_pkg::OP_LU12I) &&
                  (rd != '0);

    // lu12i shifts up, the rest sign extend
    assign imm = (op == core_pkg::OP_LU12I) ?
                 {uimm, {(`INST_ADDR_WIDTH - core_pkg::UIMM_W){1'b0}}} :
                 {{(`INST_ADDR_WIDTH - core_pkg::IMM_W){imm16[core_pkg::IMM_W-1]}}, imm16};

    // register read, index 0 reads zero
    assign rdata1 = (src1 == '0) ? '0 : regs[src1];
    assign rdata2 = (src2 == '0) ? '0 : regs[src2];

    ////////////////////
    // interlock
    ////////////////////

    // also waits on its own rd so one writer per register is in flight
    assign hazard    = (use1 && pending[src1]) || (use2 && pending[src2]) ||
                       (wen && pending[rd]);
    assign can_issue = !hazard && (!ex_valid || ex_ready);
    // a flush swallows the fetch so the redirect is never held off
    assign dec_ready = can_issue || flush;
    assign accept    = fetch_valid && can_issue && !flush;

    // backward conditional branches and b predicted taken
    assign pred_taken  = accept &&
                         ((op == core_pkg::OP_B) || (is_cond_br && imm16[core_pkg::IMM_W-1]));
    assign pred_target = fetch_pc + imm;

    always_comb begin
        pending_next = pending;
        if (wb_fire) begin
            pending_next[wb_rd] = 1'b0;
        end
        // squashed item in the execute slot will never write back
        if (flush && ex_valid && ex_wen) begin
            pending_next[ex_rd] = 1'b0;
        end
        if (accept && wen) begin
            pending_next[rd] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            pending <= pending_next;
        end
    end

    // register file, written at the writeback handshake
    always_ff @(posedge clk) begin
        if (wb_fire && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    ////////////////////
    // execute slot
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ex_valid <= 1'b0;
        end else if (!ex_valid || ex_ready) begin
            ex_valid <= fetch_valid && !hazard;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ex_op         <= op;
            ex_pc         <= fetch_pc;
            ex_rd         <= rd;
            ex_a          <= rdata1;
            ex_b          <= rdata2;
            ex_imm        <= imm;
            ex_wen        <= wen;
            ex_pred_taken <= pred_taken;
            ex_exc        <= fetch_exc;
        end
    end

endmodule

// ==== logic/execute_stage.sv ====
`include "core_defines.svh"

module execute_stage (
    input  logic                            clk,
    input  logic                            rst,
    // from decode
    input  logic                            ex_valid,
    output logic                            ex_ready,
    input  core_pkg::opcode_e               ex_op,
    input  logic [`INST_ADDR_WIDTH-1:0]     ex_pc,
    input  logic [core_pkg::REG_ADDR_W-1:0] ex_rd,
    input  logic [`INST_ADDR_WIDTH-1:0]     ex_a,
    input  logic [`INST_ADDR_WIDTH-1:0]     ex_b,
    input  logic [`INST_ADDR_WIDTH-1:0]     ex_imm,
    input  logic                            ex_wen,
    input  logic                            ex_pred_taken,
    input  core_pkg::exc_cause_e            ex_exc,
    // to result
    output logic                            res_valid,
    input  logic                            res_ready,
    output logic [core_pkg::REG_ADDR_W-1:0] res_rd,
    output logic [`INST_ADDR_WIDTH-1:0]     res_data,
    output logic                            res_wen,
    output logic [`INST_ADDR_WIDTH-1:0]     res_pc,
    output core_pkg::exc_cause_e            res_exc,
    // redirects
    output logic                            branch_flush,
    output logic [`INST_ADDR_WIDTH-1:0]     branch_actual_addr,
    input  logic                            exception_flush
);

    logic                        fire;
    logic                        is_branch;
    logic                        taken;
    logic [`INST_ADDR_WIDTH-1:0] alu_out;
    logic [`INST_ADDR_WIDTH-1:0] target;
    logic [`INST_ADDR_WIDTH-1:0] seq_pc;

    assign ex_ready = !res_valid || res_ready;
    assign fire     = ex_valid && ex_ready;

    ////////////////////
    // alu and compare
    ////////////////////

    always_comb begin
        alu_out   = '0;
        is_branch = 1'b0;
        taken     = 1'b0;
        case (ex_op)
            core_pkg::OP_ADDI:  alu_out = ex_a + ex_imm;
            core_pkg::OP_ADD:   alu_out = ex_a + ex_b;
            core_pkg::OP_SUB:   alu_out = ex_a - ex_b;
            core_pkg::OP_AND:   alu_out = ex_a & ex_b;
            core_pkg::OP_OR:    alu_out = ex_a | ex_b;
            // immediate already shifted in decode
            core_pkg::OP_LU12I: alu_out = ex_imm;
            core_pkg::OP_BEQ: begin
                is_branch = 1'b1;
                taken     = (ex_a == ex_b);
            end
            core_pkg::OP_BNE: begin
                is_branch = 1'b1;
                taken     = (ex_a != ex_b);
            end
            core_pkg::OP_B: begin
                is_branch = 1'b1;
                taken     = 1'b1;
            end
            default: ;
        endcase
    end

    ////////////////////
    // branch resolve
    ////////////////////

    // offset is relative to the branch itself
    assign target = ex_pc + ex_imm;
    assign seq_pc = ex_pc + 32'd4;

    // misaligned targets go out as is, fetch tags them ADEF
    assign branch_actual_addr = taken ? target : seq_pc;

    // only the fetch behind the branch is younger, decode drops it
    // an exception flush in the same cycle takes over
    assign branch_flush = fire && is_branch && (taken != ex_pred_taken) && !exception_flush;

    ////////////////////
    // result slot
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst || exception_flush) begin
            res_valid <= 1'b0;
        end else if (ex_ready) begin
            res_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            res_rd   <= ex_rd;
            res_data <= alu_out;
            res_wen  <= ex_wen;
            res_pc   <= ex_pc;
            res_exc  <= ex_exc;
        end
    end

endmodule

// ==== logic/result_stage.sv ====
`include "core_defines.svh"

module result_stage (
    input  logic                            clk,
    input  logic                            rst,
    // from execute
    input  logic                            res_valid,
    output logic                            res_ready,
    input  logic [core_pkg::REG_ADDR_W-1:0] res_rd,
    input  logic [`INST_ADDR_WIDTH-1:0]     res_data,
    input  logic                            res_wen,
    input  logic [`INST_ADDR_WIDTH-1:0]     res_pc,
    input  core_pkg::exc_cause_e            res_exc,
    // writeback port
    output logic                            wb_valid,
    input  logic                            wb_ready,
    output logic [core_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [`INST_ADDR_WIDTH-1:0]     wb_data,
    // exception report
    output logic                            exc_valid,
    output core_pkg::exc_cause_e            exc_cause,
    output logic [`INST_ADDR_WIDTH-1:0]     exc_pc,
    output logic                            exception_flush
);

    logic fire;
    logic is_write;

    // single entry, frees when the held item is taken
    assign res_ready = !wb_valid || wb_ready;
    assign fire      = res_valid && res_ready;

    // tagged items flush instead of writing back
    assign exception_flush = fire && (res_exc != core_pkg::EXC_NONE);
    // r0 writes and non-writing ops never show up on wb
    assign is_write = res_valid && res_wen && (res_rd != '0) &&
                      (res_exc == core_pkg::EXC_NONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid  <= 1'b0;
            exc_valid <= 1'b0;
        end else begin
            if (res_ready) begin
                wb_valid <= is_write;
            end
            // one cycle pulse per exception
            exc_valid <= exception_flush;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            wb_rd   <= res_rd;
            wb_data <= res_data;
        end
        if (exception_flush) begin
            exc_cause <= res_exc;
            exc_pc    <= res_pc;
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f files.f \
    --top-module core_tb \
    --Mdir obj_dir \
    -o core_tb_sim

./obj_dir/core_tb_sim | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
